/* Bender.yml */
package:
  name: msx_io

sources:
  - logic/msx_pkg.sv
  - logic/cpu_bus_if.sv
  - logic/io_cycle_fsm.sv
  - logic/dev_ppi.sv
  - logic/dev_vdp_timer.sv
  - logic/msx_devices.sv
  - logic/msx_io_top.sv
  - target: test
    files:
      - tests/msx_io_checker.sv
      - tests/msx_io_tb.sv

/* logic/cpu_bus_if.sv */
// Internal CPU I/O strobe bus with master and device views
`default_nettype none

interface cpu_bus_if;

    // Port number and write data, stable for the whole strobe
    msx_pkg::io_port_t addr;
    msx_pkg::io_data_t wdata;

    // One-cycle read and write strobes, never high together
    logic rd;
    logic wr;

    // Cycle sequencer side
    modport master_mp (
        output addr,
        output wdata,
        output rd,
        output wr
    );

    // Peripheral side
    modport device_mp (
        input addr,
        input wdata,
        input rd,
        input wr
    );

endinterface

`default_nettype wire

/* logic/dev_ppi.sv */
// PPI-like device with slot select, keyboard row select and row readback
`default_nettype none

module dev_ppi (
    input  logic                clk,
    input  logic                rst_n,
    cpu_bus_if.device_mp        cpu_bus,
    input  msx_pkg::kb_matrix_t kb_matrix,
    output msx_pkg::io_data_t   slot_config,
    output msx_pkg::io_data_t   data
);

    logic [3:0] row_sel;
    logic [6:0] row_base;

    // Register writes land at the end of the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_config <= 8'h00;
            row_sel     <= 4'h0;
        end else if (cpu_bus.wr) begin
            if (cpu_bus.addr == msx_pkg::PORT_PPI_A) begin
                slot_config <= cpu_bus.wdata;
            end
            if (cpu_bus.addr == msx_pkg::PORT_PPI_C) begin
                row_sel <= cpu_bus.wdata[3:0];
            end
        end
    end

    // Bit offset of the selected row in the matrix
    assign row_base = {row_sel, 3'b000};

    // Read mux, idle value when not addressed
    always_comb begin
        data = msx_pkg::IO_IDLE;
        if (cpu_bus.rd) begin
            case (cpu_bus.addr)
                msx_pkg::PORT_PPI_A: data = slot_config;
                msx_pkg::PORT_PPI_B: begin
                    // Rows past the matrix read as no key pressed
                    if (row_sel < msx_pkg::KB_ROWS) begin
                        data = kb_matrix[row_base +: 8];
                    end
                end
                msx_pkg::PORT_PPI_C: data = {4'h0, row_sel};
                default: data = msx_pkg::IO_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/dev_vdp_timer.sv */
// VDP-like interrupt timer with programmable period and read-to-clear status
`default_nettype none

module dev_vdp_timer (
    input  logic                clk,
    input  logic                rst_n,
    cpu_bus_if.device_mp        cpu_bus,
    output logic                interrupt,
    output msx_pkg::io_data_t   data
);

    logic [7:0] period;
    logic [7:0] count;
    logic [7:0] count_next;
    logic       running;
    logic       ctrl_wr;
    logic       status_rd;
    logic       flag_set;

    assign ctrl_wr   = cpu_bus.wr && (cpu_bus.addr == msx_pkg::PORT_VDP_CTRL);
    assign status_rd = cpu_bus.rd && (cpu_bus.addr == msx_pkg::PORT_VDP_CTRL);

    // Period 0 holds the counter
    assign running = (period != 8'h00);

    // Count runs 0 .. period-1, then wraps
    assign count_next = (count == period - 8'd1) ? 8'h00 : count + 8'd1;

    // Flag sets on the edge where the count arrives at period-1
    assign flag_set = running && !ctrl_wr && (count_next == period - 8'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period <= 8'h00;
            count  <= 8'h00;
        end else if (ctrl_wr) begin
            // New period restarts the count
            period <= cpu_bus.wdata;
            count  <= 8'h00;
        end else if (running) begin
            count <= count_next;
        end
    end

    // Sticky flag, a set wins over a clearing read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            interrupt <= 1'b0;
        end else if (flag_set) begin
            interrupt <= 1'b1;
        end else if (status_rd) begin
            interrupt <= 1'b0;
        end
    end

    // Status byte, flag in bit 7
    assign data = status_rd ? {interrupt, 7'b000_0000} : msx_pkg::IO_IDLE;

endmodule

`default_nettype wire

/* logic/io_cycle_fsm.sv */
// I/O cycle FSM turning host requests into bus strobes and response pulses
`default_nettype none

module io_cycle_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                req_write,
    input  msx_pkg::io_port_t   req_port,
    input  msx_pkg::io_data_t   req_wdata,
    output logic                rsp_valid,
    output msx_pkg::io_data_t   rsp_rdata,
    input  msx_pkg::io_data_t   rdata,
    cpu_bus_if.master_mp        cpu_bus
);

    msx_pkg::cycle_state_t state;

    // One request in flight at a time
    assign req_ready = (state == msx_pkg::CYC_IDLE);
    assign rsp_valid = (state == msx_pkg::CYC_DONE);

    // Sequencer and strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= msx_pkg::CYC_IDLE;
            cpu_bus.rd <= 1'b0;
            cpu_bus.wr <= 1'b0;
        end else begin
            unique case (state)
                msx_pkg::CYC_IDLE: begin
                    if (req_valid) begin
                        state      <= msx_pkg::CYC_STROBE;
                        cpu_bus.rd <= !req_write;
                        cpu_bus.wr <= req_write;
                    end
                end
                msx_pkg::CYC_STROBE: begin
                    state      <= msx_pkg::CYC_DONE;
                    cpu_bus.rd <= 1'b0;
                    cpu_bus.wr <= 1'b0;
                end
                msx_pkg::CYC_DONE: begin
                    state <= msx_pkg::CYC_IDLE;
                end
                default: begin
                    state <= msx_pkg::CYC_IDLE;
                end
            endcase
        end
    end

    // Bus fields latched on acceptance, response data at end of strobe
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cpu_bus.addr  <= req_port;
            cpu_bus.wdata <= req_wdata;
        end
        if (state == msx_pkg::CYC_STROBE) begin
            // Writes report the idle bus value
            rsp_rdata <= cpu_bus.rd ? rdata : msx_pkg::IO_IDLE;
        end
    end

endmodule

`default_nettype wire

/* logic/msx_devices.sv */
// Device aggregator combining read data by AND and interrupts by OR
`default_nettype none

module msx_devices (
    cpu_bus_if.device_mp        cpu_bus,
    input  logic                clk,
    input  logic                rst_n,
    input  msx_pkg::kb_matrix_t kb_matrix,
    output msx_pkg::io_data_t   slot_config,
    output msx_pkg::io_data_t   rdata,
    output logic                interrupt
);

    msx_pkg::io_data_t ppi_data;
    msx_pkg::io_data_t vdp_data;
    logic              vdp_interrupt;

    // Idle devices drive all ones, so AND leaves only the addressed one
    assign rdata = ppi_data & vdp_data;

    // Interrupt sources are ORed, the timer is the only one so far
    assign interrupt = vdp_interrupt;

    // Slot and keyboard
    dev_ppi dev_ppi (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_bus     (cpu_bus),
        .kb_matrix   (kb_matrix),
        .slot_config (slot_config),
        .data        (ppi_data)
    );

    // Frame interrupt timer
    dev_vdp_timer dev_vdp_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_bus   (cpu_bus),
        .interrupt (vdp_interrupt),
        .data      (vdp_data)
    );

endmodule

`default_nettype wire

/* logic/msx_io_top.sv */
// Top level joining the I/O cycle FSM and the device aggregator
`default_nettype none

module msx_io_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                req_write,
    input  msx_pkg::io_port_t   req_port,
    input  msx_pkg::io_data_t   req_wdata,
    output logic                rsp_valid,
    output msx_pkg::io_data_t   rsp_rdata,
    input  msx_pkg::kb_matrix_t kb_matrix,
    output msx_pkg::io_data_t   slot_config,
    output logic                interrupt
);

    cpu_bus_if cpu_bus ();

    msx_pkg::io_data_t rdata;

    io_cycle_fsm io_cycle_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_port  (req_port),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rdata     (rdata),
        .cpu_bus   (cpu_bus.master_mp)
    );

    msx_devices msx_devices (
        .cpu_bus     (cpu_bus.device_mp),
        .clk         (clk),
        .rst_n       (rst_n),
        .kb_matrix   (kb_matrix),
        .slot_config (slot_config),
        .rdata       (rdata),
        .interrupt   (interrupt)
    );

endmodule

`default_nettype wire

/* logic/msx_pkg.sv */
// Port map, bus widths, idle bus value and the I/O cycle state type
`default_nettype none

package msx_pkg;

    // I/O bus fields
    typedef logic [7:0] io_port_t;
    typedef logic [7:0] io_data_t;

    // Eleven keyboard rows of eight keys, row r at bits 8r+7:8r, 0 = pressed
    typedef logic [87:0] kb_matrix_t;

    // States of the host-to-bus cycle sequencer
    typedef enum logic [1:0] {
        CYC_IDLE,
        CYC_STROBE,
        CYC_DONE
    } cycle_state_t;

    // Value seen on the data bus when no device answers
    localparam io_data_t IO_IDLE = 8'hFF;

    localparam int KB_ROWS = 11;

    // Port numbers
    localparam io_port_t PORT_VDP_CTRL = 8'h99;
    localparam io_port_t PORT_PPI_A    = 8'hA8;
    localparam io_port_t PORT_PPI_B    = 8'hA9;
    localparam io_port_t PORT_PPI_C    = 8'hAA;

endpackage

`default_nettype wire

/* src.f */
logic/msx_pkg.sv
logic/cpu_bus_if.sv
logic/io_cycle_fsm.sv
logic/dev_ppi.sv
logic/dev_vdp_timer.sv
logic/msx_devices.sv
logic/msx_io_top.sv
tests/msx_io_checker.sv
tests/msx_io_tb.sv

/* tests/msx_io_checker.sv */
// Concurrent assertions on the host request/response protocol and the bus strobes
`default_nettype none

module msx_io_checker (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_ready,
    input logic rsp_valid,
    input logic rd,
    input logic wr
);
    timeunit 1ns;
    timeprecision 100ps;

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(rd && wr))
        else $error("rd and wr strobes high together");

    // Response pulse two cycles after acceptance
    rsp_after_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready) |-> ##2 rsp_valid)
        else $error("rsp_valid missing two cycles after a transfer");

    ready_low_in_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> !req_ready)
        else $error("req_ready high during rsp_valid");

    rsp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held for two cycles");

endmodule

bind msx_io_top msx_io_checker protocol_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rd        (cpu_bus.rd),
    .wr        (cpu_bus.wr)
);

`default_nettype wire

/* tests/msx_io_tb.sv */
// Testbench for msx_io_top with reference model, compare process and test summary
`default_nettype none

module msx_io_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 100;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    logic                req_ready;
    logic                req_write;
    msx_pkg::io_port_t   req_port;
    msx_pkg::io_data_t   req_wdata;
    logic                rsp_valid;
    msx_pkg::io_data_t   rsp_rdata;
    msx_pkg::kb_matrix_t kb_matrix;
    msx_pkg::io_data_t   slot_config;
    logic                interrupt;

    // Reference model state
    msx_pkg::io_data_t   slot_m;
    logic [3:0]          row_m;
    logic                flag_m;
    msx_pkg::io_data_t   exp_q[$];
    msx_pkg::io_port_t   mapped[4] = '{8'h99, 8'hA8, 8'hA9, 8'hAA};
    msx_pkg::io_port_t   unmapped[6] = '{8'h00, 8'h98, 8'hA0, 8'hAB, 8'hFF, 8'h7C};

    integer seed = 32'h9aec;
    int     errors = 0;
    int     checks = 0;
    int     test_errors = 0;

    msx_io_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_port    (req_port),
        .req_wdata   (req_wdata),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .kb_matrix   (kb_matrix),
        .slot_config (slot_config),
        .interrupt   (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected read data for a port, from the device register rules
    function automatic msx_pkg::io_data_t expected_read(input msx_pkg::io_port_t port);
        case (port)
            msx_pkg::PORT_PPI_A: return slot_m;
            msx_pkg::PORT_PPI_B: begin
                if (int'(row_m) < msx_pkg::KB_ROWS) begin
                    return kb_matrix[int'(row_m) * 8 +: 8];
                end
                return msx_pkg::IO_IDLE;
            end
            msx_pkg::PORT_PPI_C:    return {4'h0, row_m};
            msx_pkg::PORT_VDP_CTRL: return {flag_m, 7'b000_0000};
            default:                return msx_pkg::IO_IDLE;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic check_byte(input string name, input msx_pkg::io_data_t got,
                              input msx_pkg::io_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-10s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // One host transfer, returns once the response pulse has been seen
    task automatic io_access(input logic write, input msx_pkg::io_port_t port,
                             input msx_pkg::io_data_t wdata, output msx_pkg::io_data_t rdata);
        int waited;
        exp_q.push_back(write ? msx_pkg::IO_IDLE : expected_read(port));
        req_valid = 1'b1;
        req_write = write;
        req_port  = port;
        req_wdata = wdata;
        waited    = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT) abort_run("Request was never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (write && port == msx_pkg::PORT_PPI_A) slot_m = wdata;
        if (write && port == msx_pkg::PORT_PPI_C) row_m = wdata[3:0];
        if (!write && port == msx_pkg::PORT_VDP_CTRL) flag_m = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            waited++;
            if (waited > TIMEOUT) abort_run("No response for an accepted request");
            @(negedge clk);
        end
        rdata = rsp_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic io_write(input msx_pkg::io_port_t port, input msx_pkg::io_data_t wdata);
        msx_pkg::io_data_t unused;
        io_access(1'b1, port, wdata, unused);
    endtask

    task automatic io_read(input msx_pkg::io_port_t port, output msx_pkg::io_data_t rdata);
        io_access(1'b0, port, 8'h00, rdata);
    endtask

    // Compare every response against the queued expectation
    always @(negedge clk) begin
        if (rsp_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response at %0t ns with no request outstanding", $time);
            end else begin
                check_byte("rsp_rdata", rsp_rdata, exp_q.pop_front());
            end
        end
    end

    initial begin
        int                r;
        int                sel;
        msx_pkg::io_port_t port;
        msx_pkg::io_data_t data;
        logic              write;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_port  = 8'h00;
        req_wdata = 8'h00;
        kb_matrix = '1;
        slot_m    = 8'h00;
        row_m     = 4'h0;
        flag_m    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_byte("req_ready", {7'b0, req_ready}, 8'h01);
        check_byte("rsp_valid", {7'b0, rsp_valid}, 8'h00);
        check_byte("interrupt", {7'b0, interrupt}, 8'h00);
        check_byte("slot_config", slot_config, 8'h00);
        @(posedge clk);
        #1;
        finish_test("reset");

        repeat (8) begin
            io_write(msx_pkg::PORT_PPI_A, 8'($random(seed)));
            check_byte("slot_config", slot_config, slot_m);
            io_read(msx_pkg::PORT_PPI_A, data);
        end
        finish_test("slot");

        kb_matrix = {24'($random(seed)), 32'($random(seed)), 32'($random(seed))};
        for (r = 0; r < 16; r++) begin
            // High nibble is ignored by the row select
            io_write(msx_pkg::PORT_PPI_C, {4'($random(seed)), 4'(r)});
            io_read(msx_pkg::PORT_PPI_B, data);
            io_read(msx_pkg::PORT_PPI_C, data);
        end
        finish_test("keyboard");

        for (r = 0; r < 6; r++) begin
            io_write(unmapped[r], 8'($random(seed)));
            io_read(unmapped[r], data);
            for (sel = 0; sel < 4; sel++) io_read(mapped[sel], data);
        end
        finish_test("unmapped");

        io_write(msx_pkg::PORT_VDP_CTRL, 8'd20);
        r = 0;
        while (!interrupt) begin
            r++;
            if (r > TIMEOUT) abort_run("Timer interrupt never rose");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        flag_m = 1'b1;
        io_read(msx_pkg::PORT_VDP_CTRL, data);
        check_byte("interrupt", {7'b0, interrupt}, 8'h00);
        io_write(msx_pkg::PORT_VDP_CTRL, 8'h00);
        io_read(msx_pkg::PORT_VDP_CTRL, data);
        finish_test("timer");

        repeat (200) begin
            sel   = {$random(seed)} % 6;
            port  = (sel < 4) ? mapped[sel] : 8'($random(seed));
            write = 1'($random(seed));
            data  = 8'($random(seed));
            // Keep the timer stopped
            if (port == msx_pkg::PORT_VDP_CTRL) data = 8'h00;
            io_access(write, port, data, data);
        end
        finish_test("mixed");

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_q.size());
        end
        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
